// ==== symb_pll_pkg.sv ====
// shared widths, register map and enums
// for the symbol clock pll control block

package symb_pll_pkg;

  // bus and datapath widths --------------------------------
  localparam int addr_w = 12;   // processor address
  localparam int data_w = 16;   // register / data bus
  localparam int cnt_w  = 10;   // half of a 16-bit divide, up to 2046
  localparam int nco_w  = 16;   // test nco accumulator

  // register map --------------------------------------------
  localparam logic [addr_w-1:0] reg_ref_addr = 12'h010;  // reference divide
  localparam logic [addr_w-1:0] reg_fbk_addr = 12'h011;  // feedback divide
  localparam logic [addr_w-1:0] reg_vco_addr = 12'h012;  // vco output divide
  localparam logic [addr_w-1:0] reg_nco_addr = 12'h013;  // nco step

  // decoded register select
  typedef enum logic [2:0] {
    reg_none,   // unmapped address
    reg_ref,
    reg_fbk,
    reg_vco,
    reg_nco
  } pll_reg_e;

  // phase-frequency detector states
  typedef enum logic [1:0] {
    pfd_idle,   // both pumps off
    pfd_up,     // reference leads
    pfd_dn      // feedback leads
  } pfd_state_e;

endpackage

// ==== symb_pll_regs.sv ====
// processor register file
// four config registers, synchronous write, combinational read-back

`timescale 1ns/10ps

module symb_pll_regs (
  input  logic                              clk,
  input  logic                              rs,
  input  logic                              en,      // processor select
  input  logic                              wr,      // write strobe
  input  logic [symb_pll_pkg::addr_w-1:0]   a,
  input  logic [symb_pll_pkg::data_w-1:0]   di,
  output logic [symb_pll_pkg::data_w-1:0]   rdata,   // read-back
  output logic [symb_pll_pkg::data_w-1:0]   ref_div,
  output logic [symb_pll_pkg::data_w-1:0]   fbk_div,
  output logic [symb_pll_pkg::data_w-1:0]   vco_div,
  output logic [symb_pll_pkg::data_w-1:0]   nco_step
);

  import symb_pll_pkg::*;

  pll_reg_e sel;  // decoded address

  // address decode -------------------------------------------
  always_comb begin
    case (a)
      reg_ref_addr: sel = reg_ref;
      reg_fbk_addr: sel = reg_fbk;
      reg_vco_addr: sel = reg_vco;
      reg_nco_addr: sel = reg_nco;
      default:      sel = reg_none;
    endcase
  end

  // write, lands on the sampling edge
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      ref_div  <= '0;   // all dividers start in bypass
      fbk_div  <= '0;
      vco_div  <= '0;
      nco_step <= '0;   // clk_en is the reference source
    end else if (en && wr) begin
      case (sel)
        reg_ref: ref_div  <= di;
        reg_fbk: fbk_div  <= di;
        reg_vco: vco_div  <= di;
        reg_nco: nco_step <= di;
        default: ;      // unmapped, ignored
      endcase
    end
  end

  // read mux, zero when idle or unmapped
  always_comb begin
    rdata = '0;
    if (en) begin
      case (sel)
        reg_ref: rdata = ref_div;
        reg_fbk: rdata = fbk_div;
        reg_vco: rdata = vco_div;
        reg_nco: rdata = nco_step;
        default: rdata = '0;
      endcase
    end
  end

  // a floating address while selected would corrupt a write
  a_addr_known: assert property (@(posedge clk) disable iff (rs) en |-> !$isunknown(a))
    else $error("%0t regs: address unknown while en high", $time);

endmodule

// ==== symb_ref_path.sv ====
// reference path in the clk domain
// test nco, reference source select and half-count divider -> clk_ref

`timescale 1ns/10ps

module symb_ref_path (
  input  logic                              clk,
  input  logic                              rs,
  input  logic                              clk_en,    // symbol rate enable
  input  logic [symb_pll_pkg::data_w-1:0]   ref_div,
  input  logic [symb_pll_pkg::data_w-1:0]   nco_step,
  output logic                              clk_ref    // comparator reference
);

  import symb_pll_pkg::*;

  logic [nco_w-1:0] acc;         // nco accumulator
  logic             acc_msb_d;   // msb one cycle back
  logic             nco_tick;    // overflow pulse
  logic             use_en;      // nco off, clk_en drives the divider
  logic             cnt_en;      // divider count enable
  logic             src_raw;     // undivided source for bypass
  logic [cnt_w-1:0] cnt;
  logic [cnt_w-1:0] tc;          // half the divide value
  logic             bypass;
  logic             ref_q;       // divided clock

  // test nco ------------------------------------------------
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      acc       <= '0;
      acc_msb_d <= 1'b0;
      nco_tick  <= 1'b0;
    end else begin
      acc       <= acc + nco_step;  // wraps at full scale
      acc_msb_d <= acc[nco_w-1];
      nco_tick  <= acc[nco_w-1] & ~acc_msb_d;  // one cycle after msb rise
    end
  end

  // source select
  assign use_en  = (nco_step == '0);
  assign cnt_en  = use_en ? clk_en : nco_tick;
  assign src_raw = use_en ? clk_en : acc[nco_w-1];

  // reference divider ---------------------------------------
  assign tc     = ref_div[cnt_w:1];  // odd values round down
  assign bypass = (ref_div < 16'd2);

  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      cnt   <= cnt_w'(1);
      ref_q <= 1'b0;
    end else if (bypass) begin
      cnt   <= cnt_w'(1);   // hold, restart clean on exit
      ref_q <= 1'b0;
    end else if (cnt_en) begin
      if (cnt >= tc) begin   // terminal count, also catches a smaller new ratio
        cnt   <= cnt_w'(1);
        ref_q <= ~ref_q;
      end else begin
        cnt   <= cnt + cnt_w'(1);
      end
    end
  end

  assign clk_ref = bypass ? src_raw : ref_q;

  // below half scale the msb stays high past the tick, one tick per wrap
  a_tick_single: assert property (@(posedge clk) disable iff (rs)
    (!nco_step[nco_w-1] && nco_tick) |-> acc[nco_w-1])
    else $error("%0t ref_path: accumulator msb high for one cycle only", $time);

endmodule

// ==== symb_vco_path.sv ====
// vco path in the clk_vco domain
// feedback and output half-count dividers -> clk_fbk, clk_out

`timescale 1ns/10ps

module symb_vco_path (
  input  logic                              clk_vco,   // external vco clock
  input  logic                              rs,
  input  logic [symb_pll_pkg::data_w-1:0]   fbk_div,
  input  logic [symb_pll_pkg::data_w-1:0]   vco_div,
  output logic                              clk_fbk,   // comparator feedback
  output logic                              clk_out    // filtered symbol clock
);

  import symb_pll_pkg::*;

  // index 0 feedback, index 1 output
  logic [data_w-1:0] div_val [2];
  logic [cnt_w-1:0]  cnt [2];
  logic [cnt_w-1:0]  tc [2];
  logic [1:0]        bypass;
  logic [1:0]        div_q;

  assign div_val[0] = fbk_div;
  assign div_val[1] = vco_div;

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      tc[i]     = div_val[i][cnt_w:1];     // half count, odd rounds down
      bypass[i] = (div_val[i] < 16'd2);
    end
  end

  // dividers ------------------------------------------------
  always_ff @(posedge clk_vco or posedge rs) begin
    if (rs) begin
      cnt[0] <= cnt_w'(1);
      cnt[1] <= cnt_w'(1);
      div_q  <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (bypass[i]) begin
          cnt[i]   <= cnt_w'(1);   // idle while bypassed
          div_q[i] <= 1'b0;
        end else if (cnt[i] >= tc[i]) begin
          cnt[i]   <= cnt_w'(1);
          div_q[i] <= ~div_q[i];   // half period done
        end else begin
          cnt[i]   <= cnt[i] + cnt_w'(1);
        end
      end
    end
  end

  assign clk_fbk = bypass[0] ? clk_vco : div_q[0];
  assign clk_out = bypass[1] ? clk_vco : div_q[1];

  // ratio comes from the clk domain, so skip the edge where it moves
  for (genvar g = 0; g < 2; g++) begin : g_chk
    a_cnt_range: assert property (@(posedge clk_vco) disable iff (rs)
      (!bypass[g] && $stable(div_val[g])) |-> (cnt[g] <= tc[g]))
      else $error("%0t vco_path: divider %0d counter past terminal count", $time, g);
  end

endmodule

// ==== symb_phase_det.sv ====
// digital phase-frequency detector in the clk domain
// clk_fbk synchronizer, edge detect, three-state pump control

`timescale 1ns/10ps

module symb_phase_det (
  input  logic clk,
  input  logic rs,
  input  logic clk_ref,   // already in clk domain
  input  logic clk_fbk,   // from clk_vco domain
  output logic pump_up,   // charge pump up level
  output logic pump_dn    // charge pump down level
);

  import symb_pll_pkg::*;

  logic       fbk_s1, fbk_s2;  // two-flop synchronizer
  logic       fbk_d;           // edge detect history
  logic       ref_d;
  logic       ref_edge, fbk_edge;
  pfd_state_e state, state_nx;

  // sync and edge detect -------------------------------------
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      fbk_s1 <= 1'b0;
      fbk_s2 <= 1'b0;
      fbk_d  <= 1'b0;
      ref_d  <= 1'b0;
    end else begin
      fbk_s1 <= clk_fbk;
      fbk_s2 <= fbk_s1;
      fbk_d  <= fbk_s2;
      ref_d  <= clk_ref;   // sampled directly
    end
  end

  assign ref_edge = clk_ref & ~ref_d;
  assign fbk_edge = fbk_s2 & ~fbk_d;

  // state machine --------------------------------------------
  always_comb begin
    state_nx = state;   // both edges together, no change
    case (state)
      pfd_idle: if (ref_edge && !fbk_edge) state_nx = pfd_up;
                else if (fbk_edge && !ref_edge) state_nx = pfd_dn;
      pfd_up:   if (fbk_edge && !ref_edge) state_nx = pfd_idle;
      pfd_dn:   if (ref_edge && !fbk_edge) state_nx = pfd_idle;
      default:  state_nx = pfd_idle;
    endcase
  end

  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      state   <= pfd_idle;
      pump_up <= 1'b0;
      pump_dn <= 1'b0;
    end else begin
      state   <= state_nx;
      pump_up <= (state_nx == pfd_up);   // tracks the up state
      pump_dn <= (state_nx == pfd_dn);
    end
  end

  // shorting both pumps would fight the loop filter
  a_pump_excl: assert property (@(posedge clk) disable iff (rs) !(pump_up && pump_dn))
    else $error("%0t phase_det: pump_up and pump_dn high together", $time);

endmodule

// ==== symb_pll_top.sv ====
// symbol clock pll control, top level
// registers, reference path, vco path and phase detector

`timescale 1ns/10ps

module symb_pll_top (
  input  logic                              clk,       // system clock
  input  logic                              rs,
  input  logic                              clk_en,    // symbol rate enable
  input  logic                              clk_vco,   // external vco
  input  logic                              en,
  input  logic                              wr,
  input  logic [symb_pll_pkg::addr_w-1:0]   a,
  input  logic [symb_pll_pkg::data_w-1:0]   di,
  output logic [symb_pll_pkg::data_w-1:0]   rdata,
  output logic                              clk_ref,
  output logic                              clk_fbk,
  output logic                              clk_out,
  output logic                              pump_up,
  output logic                              pump_dn
);

  import symb_pll_pkg::*;

  // quasi-static config, written in clk domain
  logic [data_w-1:0] ref_div;
  logic [data_w-1:0] fbk_div;
  logic [data_w-1:0] vco_div;
  logic [data_w-1:0] nco_step;

  symb_pll_regs symb_pll_regs_inst (
    .clk      (clk),
    .rs       (rs),
    .en       (en),
    .wr       (wr),
    .a        (a),
    .di       (di),
    .rdata    (rdata),
    .ref_div  (ref_div),
    .fbk_div  (fbk_div),
    .vco_div  (vco_div),
    .nco_step (nco_step)
  );

  // the two paths run side by side ----------------------------
  symb_ref_path symb_ref_path_inst (
    .clk      (clk),
    .rs       (rs),
    .clk_en   (clk_en),
    .ref_div  (ref_div),
    .nco_step (nco_step),
    .clk_ref  (clk_ref)
  );

  symb_vco_path symb_vco_path_inst (
    .clk_vco  (clk_vco),
    .rs       (rs),
    .fbk_div  (fbk_div),
    .vco_div  (vco_div),
    .clk_fbk  (clk_fbk),
    .clk_out  (clk_out)
  );

  // compare reference against feedback
  symb_phase_det symb_phase_det_inst (
    .clk      (clk),
    .rs       (rs),
    .clk_ref  (clk_ref),
    .clk_fbk  (clk_fbk),
    .pump_up  (pump_up),
    .pump_dn  (pump_dn)
  );

endmodule

// ==== tb_symb_pll.sv ====
// testbench for the symbol clock pll control block
// register access, divider periods, nco source, vco bypass, pump balance

`timescale 1ns/10ps

module tb_symb_pll;

  import symb_pll_pkg::*;

  logic              clk, rs, clk_en, clk_vco, en, wr;
  logic [addr_w-1:0] a;
  logic [data_w-1:0] di, rdata;
  logic              clk_ref, clk_fbk, clk_out, pump_up, pump_dn;

  int check_errs, overlap_errs, idle_read_errs;
  bit toggle_en;                          // clk_en is the reference source
  int ref_rises, fbk_rises, out_rises;    // rising edge counts
  int ref_period, ref_en_period;          // clk cycles, clk_en pulses
  int fbk_period, out_period;             // clk_vco edges
  int clk_cnt, en_cnt, fbk_cnt, out_cnt;
  bit ref_prev, fbk_prev, out_prev;
  int settle_cyc = 100;                   // pump loop settling
  int window_cyc = 500;                   // pump measurement window

  symb_pll_top symb_pll_top_inst (.*);    // names match the top level

  // clocks and enable --------------------------------
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;                // 4 ns
  end

  initial begin
    clk_vco = 1'b0;
    forever #3 clk_vco = ~clk_vco;        // free running vco, 6 ns
  end

  // one clk_en pulse every other clk while enabled
  initial begin
    clk_en = 1'b0;
    forever begin
      @(negedge clk);
      clk_en <= toggle_en ? ~clk_en : 1'b0;
    end
  end

  // period monitors ----------------------------------
  always @(posedge clk) begin
    if (clk_ref && !ref_prev) begin       // rise seen one edge late, same every time
      ref_period    = clk_cnt;
      ref_en_period = en_cnt;
      ref_rises++;
      clk_cnt = 0;
      en_cnt  = 0;
    end
    if (clk_en) en_cnt++;
    clk_cnt++;
    ref_prev = clk_ref;
  end

  // dividers move on posedge, so sample on negedge
  always @(negedge clk_vco) begin
    if (clk_fbk && !fbk_prev) begin
      fbk_period = fbk_cnt;
      fbk_rises++;
      fbk_cnt = 0;
    end
    if (clk_out && !out_prev) begin
      out_period = out_cnt;
      out_rises++;
      out_cnt = 0;
    end
    fbk_cnt++;
    out_cnt++;
    fbk_prev = clk_fbk;
    out_prev = clk_out;
  end

  a_no_overlap: assert property (@(posedge clk) disable iff (rs) !(pump_up && pump_dn))
    else begin
      overlap_errs++;
      $display("pump_up and pump_dn were high together at %0t", $time);
    end

  a_idle_read: assert property (@(posedge clk) disable iff (rs) !en |-> (rdata == '0))
    else begin
      idle_read_errs++;
      $display("[ERROR] %0t rdata expected 0 got %0d", $time, rdata);
    end

  // helpers ------------------------------------------
  task automatic check_value(input string name, input int exp, input int act);
    assert (act == exp)
      else begin
        check_errs++;
        $display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp, act);
      end
  endtask

  task automatic write_reg(input logic [addr_w-1:0] addr, input logic [data_w-1:0] val);
    @(negedge clk);
    en = 1'b1;
    wr = 1'b1;
    a  = addr;
    di = val;
    @(negedge clk);                       // landed on the rising edge between
    en = 1'b0;
    wr = 1'b0;
  endtask

  task automatic read_check(input logic [addr_w-1:0] addr, input int exp);
    @(negedge clk);
    en = 1'b1;
    a  = addr;
    #1 check_value("rdata", exp, rdata);  // zero latency read
    @(negedge clk);
    en = 1'b0;
  endtask

  function automatic logic [addr_w-1:0] reg_addr(input int i);
    return reg_ref_addr + addr_w'(i);     // map is contiguous
  endfunction

  function automatic int pick_even();
    return 2 * int'($urandom_range(5, 1)); // 2 to 10
  endfunction

  function automatic int rises_of(input int idx);
    case (idx)
      0:       return ref_rises;
      1:       return fbk_rises;
      default: return out_rises;
    endcase
  endfunction

  task automatic wait_rises(input int idx, input int n);
    int start;
    start = rises_of(idx);
    while (rises_of(idx) < start + n) @(negedge clk);
  endtask

  task automatic measure_pumps(output int up_t, output int dn_t);
    up_t = 0;
    dn_t = 0;
    repeat (settle_cyc) @(negedge clk);
    repeat (window_cyc) begin
      @(negedge clk);
      if (pump_up) up_t++;
      if (pump_dn) dn_t++;
    end
  endtask

  // watchdog
  initial begin
    int limit_ns;
    // regs, clk_en divider, nco, vco, two pump windows, margin
    limit_ns = 400 + 1000 + 1500 + 1500 + 2 * (settle_cyc + window_cyc) * 4 + 3000;
    #(limit_ns);
    $display("timeout, run did not finish within %0d ns", limit_ns);
    $display("SIMULATION FAILED");
    $finish;
  end

  // main sequence ------------------------------------
  initial begin
    int v [4];
    int d, up_t, dn_t;
    void'($urandom(32'h6df8));
    rs = 1'b1;
    en = 1'b0;
    wr = 1'b0;
    a  = '0;
    di = '0;
    toggle_en = 1'b0;
    repeat (2) @(negedge clk);
    rs = 1'b0;
    check_value("clk_ref", 0, clk_ref);
    check_value("pump_up", 0, pump_up);
    check_value("pump_dn", 0, pump_dn);
    @(negedge clk_vco);                   // bypassed outputs follow clk_vco
    #1 check_value("clk_fbk", 0, clk_fbk);
    check_value("clk_out", 0, clk_out);
    for (int i = 0; i < 4; i++) read_check(reg_addr(i), 0);

    // register access
    for (int i = 0; i < 4; i++) begin
      v[i] = pick_even();
      write_reg(reg_addr(i), 16'(v[i]));
    end
    write_reg(12'h014, 16'hffff);         // unmapped, dropped
    for (int i = 0; i < 4; i++) read_check(reg_addr(i), v[i]);
    read_check(12'h014, 0);
    @(negedge clk);
    a = reg_ref_addr;                     // selected address but en low
    #1 check_value("rdata", 0, rdata);
    for (int i = 0; i < 4; i++) write_reg(reg_addr(i), '0);

    // reference divider from clk_en
    toggle_en = 1'b1;
    for (int k = 1; k <= 3; k++) begin
      d = 1 << k;                         // 2, 4, 8
      write_reg(reg_ref_addr, 16'(d));
      wait_rises(0, 3);
      check_value("clk_ref period in clk_en pulses", 2 * (d / 2), ref_en_period);
    end
    toggle_en = 1'b0;

    // nco source, wrap every 16 clk
    write_reg(reg_ref_addr, 16'd4);
    write_reg(reg_nco_addr, 16'd4096);
    wait_rises(0, 3);
    check_value("clk_ref period in clk cycles", 16 * 2 * 2, ref_period);
    write_reg(reg_ref_addr, 16'd0);       // bypass to acc msb
    wait_rises(0, 3);
    check_value("clk_ref period in clk cycles", 16, ref_period);

    // vco path
    repeat (2) begin
      v[1] = pick_even();
      v[2] = pick_even();
      write_reg(reg_fbk_addr, 16'(v[1]));
      write_reg(reg_vco_addr, 16'(v[2]));
      wait_rises(1, 3);
      wait_rises(2, 3);
      check_value("clk_fbk period in clk_vco edges", 2 * (v[1] / 2), fbk_period);
      check_value("clk_out period in clk_vco edges", 2 * (v[2] / 2), out_period);
    end
    write_reg(reg_fbk_addr, 16'd1);
    write_reg(reg_vco_addr, 16'd0);
    repeat (4) begin
      @(posedge clk_vco);
      #1 check_value("clk_fbk", 1, clk_fbk);
      check_value("clk_out", 1, clk_out);
      @(negedge clk_vco);
      #1 check_value("clk_fbk", 0, clk_fbk);
      check_value("clk_out", 0, clk_out);
    end

    // fast reference, 32 ns against 96 ns feedback
    write_reg(reg_nco_addr, 16'd16384);   // tick every 4 clk
    write_reg(reg_ref_addr, 16'd2);
    write_reg(reg_fbk_addr, 16'd16);
    measure_pumps(up_t, dn_t);
    assert (up_t > dn_t)
      else begin
        check_errs++;
        $display("fast reference gave no pump_up excess, up %0d dn %0d", up_t, dn_t);
      end
    // slow reference, 256 ns against 24 ns
    write_reg(reg_ref_addr, 16'd16);
    write_reg(reg_fbk_addr, 16'd4);
    measure_pumps(up_t, dn_t);
    assert (dn_t > up_t)
      else begin
        check_errs++;
        $display("fast feedback gave no pump_dn excess, up %0d dn %0d", up_t, dn_t);
      end

    $display("summary: %0d check errors, %0d pump overlap errors, %0d idle read errors",
             check_errs, overlap_errs, idle_read_errs);
    if (check_errs + overlap_errs + idle_read_errs == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== list.f ====
symb_pll_pkg.sv
symb_pll_regs.sv
symb_ref_path.sv
symb_vco_path.sv
symb_phase_det.sv
symb_pll_top.sv
tb_symb_pll.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the symbol clock pll testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
  --top-module tb_symb_pll -f list.f -o tb_symb_pll > build.log 2>&1 \
  || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/tb_symb_pll > sim.log 2>&1
cat sim.log
grep -q "^SIMULATION PASSED$" sim.log && echo "run passed" \
  || { echo "run failed"; exit 1; }
